//--- include/falling_piece_macros.svh
`ifndef FALLING_PIECE_MACROS_SVH
`define FALLING_PIECE_MACROS_SVH

// well size in cells
`define GRID_ROWS 22
`define GRID_COLS 11

// screen geometry
`define CELL_PIXELS 9
`define ORIGIN_X 270   // pixel x of cell (0,0)
`define ORIGIN_Y 135   // pixel y of cell (0,0)
`define PIXEL_W 10

// where a new piece appears
`define SPAWN_COL 3
`define SPAWN_ROW 0

// tick counts between moves
`define DROP_TICKS 50
`define FAST_DROP_TICKS 5   // down key held
`define HORIZ_TICKS 6

`endif

//--- verilog/falling_piece_pkg.sv
`default_nettype none

`include "falling_piece_macros.svh"

package falling_piece_pkg;

    // every shape in every orientation it can take
    typedef enum logic [4:0] {
        O,
        I_HORIZ,
        I_VERT,
        Z_HORIZ,
        Z_VERT,
        S_HORIZ,
        S_VERT,
        J_UP,
        J_DOWN,
        J_LEFT,
        J_RIGHT,
        L_UP,
        L_DOWN,
        L_LEFT,
        L_RIGHT,
        T_UP,
        T_DOWN,
        T_LEFT,
        T_RIGHT
    } piece_shape_e;

    // keyboard scan codes
    typedef enum logic [7:0] {
        KEY_DOWN  = 8'h1B,
        KEY_LEFT  = 8'h1C,
        KEY_RIGHT = 8'h23
    } key_cmd_e;

    typedef enum logic {
        FALLING,
        LANDED
    } motion_state_e;

    typedef logic [3:0][3:0] shape_mask_t;   // [row][col] from the anchor
    typedef logic [4:0] grid_row_t;
    typedef logic [3:0] grid_col_t;
    typedef logic [`GRID_ROWS-1:0][`GRID_COLS-1:0] board_t;

endpackage

`default_nettype wire

//--- verilog/probe_if.sv
`timescale 1ns/1ps
`default_nettype none

interface probe_if;

    falling_piece_pkg::grid_row_t anchor_row;
    falling_piece_pkg::grid_col_t anchor_col;
    logic blocked_down;
    logic blocked_left;
    logic blocked_right;

    modport mover (
        output anchor_row, anchor_col,
        input  blocked_down, blocked_left, blocked_right
    );

    modport check (
        input  anchor_row, anchor_col,
        output blocked_down, blocked_left, blocked_right
    );

endinterface

`default_nettype wire

//--- verilog/shape_mask_rom.sv
`timescale 1ns/1ps
`default_nettype none

module shape_mask_rom (
    input  falling_piece_pkg::piece_shape_e shape,
    output falling_piece_pkg::shape_mask_t  mask
);

    // each entry lists rows 3 down to 0, bit c of a row is column c
    always_comb begin
        case (shape)
            falling_piece_pkg::O:       mask = {4'b0000, 4'b0000, 4'b0011, 4'b0011};
            falling_piece_pkg::I_HORIZ: mask = {4'b0000, 4'b0000, 4'b0000, 4'b1111};
            falling_piece_pkg::I_VERT:  mask = {4'b0001, 4'b0001, 4'b0001, 4'b0001};
            falling_piece_pkg::Z_HORIZ: mask = {4'b0000, 4'b0000, 4'b0110, 4'b0011};
            falling_piece_pkg::Z_VERT:  mask = {4'b0000, 4'b0001, 4'b0011, 4'b0010};
            falling_piece_pkg::S_HORIZ: mask = {4'b0000, 4'b0000, 4'b0011, 4'b0110};
            falling_piece_pkg::S_VERT:  mask = {4'b0000, 4'b0010, 4'b0011, 4'b0001};

            // J family, foot on the left when upright
            falling_piece_pkg::J_UP:    mask = {4'b0000, 4'b0011, 4'b0010, 4'b0010};
            falling_piece_pkg::J_DOWN:  mask = {4'b0000, 4'b0001, 4'b0001, 4'b0011};
            falling_piece_pkg::J_LEFT:  mask = {4'b0000, 4'b0000, 4'b0100, 4'b0111};
            falling_piece_pkg::J_RIGHT: mask = {4'b0000, 4'b0000, 4'b0111, 4'b0001};

            falling_piece_pkg::L_UP:    mask = {4'b0000, 4'b0011, 4'b0001, 4'b0001};
            falling_piece_pkg::L_DOWN:  mask = {4'b0000, 4'b0010, 4'b0010, 4'b0011};
            falling_piece_pkg::L_LEFT:  mask = {4'b0000, 4'b0000, 4'b0111, 4'b0100};
            falling_piece_pkg::L_RIGHT: mask = {4'b0000, 4'b0000, 4'b0001, 4'b0111};

            // T named by where the nub points
            falling_piece_pkg::T_UP:    mask = {4'b0000, 4'b0000, 4'b0111, 4'b0010};
            falling_piece_pkg::T_DOWN:  mask = {4'b0000, 4'b0000, 4'b0010, 4'b0111};
            falling_piece_pkg::T_LEFT:  mask = {4'b0000, 4'b0010, 4'b0011, 4'b0010};
            falling_piece_pkg::T_RIGHT: mask = {4'b0000, 4'b0001, 4'b0011, 4'b0001};

            default:                    mask = '0;   // unused codes
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/collision_probe.sv
`timescale 1ns/1ps
`default_nettype none

`include "falling_piece_macros.svh"

module collision_probe (
    input  falling_piece_pkg::piece_shape_e shape,
    input  falling_piece_pkg::board_t       board,
    probe_if.check                          probe
);

    falling_piece_pkg::shape_mask_t mask;

    shape_mask_rom u_mask_rom (
        .shape (shape),
        .mask  (mask)
    );

    // walk all 16 mask cells, any set cell can block a direction
    always_comb begin
        int row;
        int col;

        probe.blocked_down  = 1'b0;
        probe.blocked_left  = 1'b0;
        probe.blocked_right = 1'b0;

        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                row = int'(probe.anchor_row) + r;
                col = int'(probe.anchor_col) + c;

                if (mask[r][c]) begin
                    // floor, or stack under the cell
                    if (row + 1 >= `GRID_ROWS || col >= `GRID_COLS)
                        probe.blocked_down = 1'b1;
                    else if (board[row + 1][col])
                        probe.blocked_down = 1'b1;

                    if (col == 0 || row >= `GRID_ROWS || col - 1 >= `GRID_COLS)
                        probe.blocked_left = 1'b1;   // left wall
                    else if (board[row][col - 1])
                        probe.blocked_left = 1'b1;

                    if (col + 1 >= `GRID_COLS || row >= `GRID_ROWS)
                        probe.blocked_right = 1'b1;  // right wall
                    else if (board[row][col + 1])
                        probe.blocked_right = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/step_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "falling_piece_macros.svh"

module step_timer (
    input  logic Clk,
    input  logic reset,
    input  logic frame_clk,
    input  logic fast,
    input  logic horiz_req,
    input  logic restart,
    output logic tick,
    output logic drop_due,
    output logic horiz_due
);

    localparam int drop_w  = $clog2(`DROP_TICKS + 1);
    localparam int horiz_w = $clog2(`HORIZ_TICKS + 1);

    logic [1:0]         frame_sync;
    logic               frame_prev;
    logic [drop_w-1:0]  drop_cnt;
    logic [drop_w-1:0]  drop_next;
    logic [drop_w-1:0]  drop_period;
    logic [horiz_w-1:0] horiz_cnt;
    logic [horiz_w-1:0] horiz_next;

    // frame strobe comes from a slow clock domain
    always_ff @(posedge Clk) begin
        if (reset) begin
            frame_sync <= '0;
            frame_prev <= 1'b0;
        end else begin
            frame_sync <= {frame_sync[0], frame_clk};
            frame_prev <= frame_sync[1];
        end
    end

    assign tick = frame_sync[1] & ~frame_prev;   // rising edge only

    assign drop_period = fast ? drop_w'(`FAST_DROP_TICKS) : drop_w'(`DROP_TICKS);
    assign drop_next   = drop_cnt + 1'b1;
    assign drop_due    = tick && (drop_next >= drop_period);  // >= so a fast switch fires late count

    assign horiz_next = horiz_cnt + 1'b1;
    assign horiz_due  = tick && horiz_req && (horiz_next == horiz_w'(`HORIZ_TICKS));

    always_ff @(posedge Clk) begin
        if (reset || restart) begin
            drop_cnt  <= '0;
            horiz_cnt <= '0;
        end else if (tick) begin
            drop_cnt <= drop_due ? '0 : drop_next;
            if (horiz_due)
                horiz_cnt <= '0;
            else if (horiz_req)
                horiz_cnt <= horiz_next;   // holds while no side key
        end
    end

    // counters never pass their periods
    a_counts_in_range: assert property (@(posedge Clk) disable iff (reset)
        drop_cnt < drop_w'(`DROP_TICKS) && horiz_cnt < horiz_w'(`HORIZ_TICKS));

endmodule

`default_nettype wire

//--- verilog/piece_motion_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "falling_piece_macros.svh"

module piece_motion_fsm (
    input  logic                         Clk,
    input  logic                         reset,
    input  falling_piece_pkg::key_cmd_e  keycode,
    input  logic                         keypress,
    input  logic                         tick,
    input  logic                         drop_due,
    input  logic                         horiz_due,
    output logic                         fast,
    output logic                         horiz_req,
    output logic                         restart,
    probe_if.mover                       probe,
    output logic                         at_bottom,
    output logic [`PIXEL_W-1:0]          x_pos,
    output logic [`PIXEL_W-1:0]          y_pos
);

    localparam int pix_w = `PIXEL_W;
    localparam falling_piece_pkg::grid_row_t spawn_row = `SPAWN_ROW;
    localparam falling_piece_pkg::grid_col_t spawn_col = `SPAWN_COL;

    falling_piece_pkg::motion_state_e state_q;
    falling_piece_pkg::grid_row_t     row_q;
    falling_piece_pkg::grid_col_t     col_q;
    logic key_left;
    logic key_right;
    logic dir_left_q;

    assign key_left  = keypress && (keycode == falling_piece_pkg::KEY_LEFT);
    assign key_right = keypress && (keycode == falling_piece_pkg::KEY_RIGHT);
    assign fast      = keypress && (keycode == falling_piece_pkg::KEY_DOWN);
    assign horiz_req = key_left || key_right;

    // last sideways key seen
    always_ff @(posedge Clk) begin
        if (reset)
            dir_left_q <= 1'b0;
        else if (horiz_req)
            dir_left_q <= key_left;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state_q <= falling_piece_pkg::FALLING;
            row_q   <= spawn_row;
            col_q   <= spawn_col;
        end else begin
            case (state_q)
                falling_piece_pkg::FALLING: begin
                    if (tick) begin
                        if (probe.blocked_down) begin
                            // landed, next piece starts at spawn
                            state_q <= falling_piece_pkg::LANDED;
                            row_q   <= spawn_row;
                            col_q   <= spawn_col;
                        end else begin
                            if (horiz_due) begin
                                if (dir_left_q && !probe.blocked_left)
                                    col_q <= col_q - 1'b1;
                                else if (!dir_left_q && !probe.blocked_right)
                                    col_q <= col_q + 1'b1;
                            end
                            if (drop_due)
                                row_q <= row_q + 1'b1;
                        end
                    end
                end
                falling_piece_pkg::LANDED: state_q <= falling_piece_pkg::FALLING;
            endcase
        end
    end

    assign at_bottom = (state_q == falling_piece_pkg::LANDED);
    assign restart   = at_bottom;   // timer starts over with the new piece

    assign probe.anchor_row = row_q;
    assign probe.anchor_col = col_q;

    assign x_pos = pix_w'(`ORIGIN_X + int'(col_q) * `CELL_PIXELS);
    assign y_pos = pix_w'(`ORIGIN_Y + int'(row_q) * `CELL_PIXELS);

    a_single_landing: assert property (@(posedge Clk) disable iff (reset)
        at_bottom |=> !at_bottom);

    a_col_in_well: assert property (@(posedge Clk) disable iff (reset)
        int'(probe.anchor_col) < `GRID_COLS);

endmodule

`default_nettype wire

//--- verilog/falling_piece_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "falling_piece_macros.svh"

module falling_piece_top (
    input  logic                            Clk,
    input  logic                            reset,
    input  logic                            frame_clk,
    input  logic [7:0]                      keycode,
    input  logic                            keypress,
    input  falling_piece_pkg::piece_shape_e shape,
    input  falling_piece_pkg::board_t       board,
    output logic                            at_bottom,
    output logic [`PIXEL_W-1:0]             x_pos,
    output logic [`PIXEL_W-1:0]             y_pos
);

    logic tick;
    logic drop_due;
    logic horiz_due;
    logic fast;
    logic horiz_req;
    logic restart;

    probe_if probe ();

    step_timer u_step_timer (
        .Clk       (Clk),
        .reset     (reset),
        .frame_clk (frame_clk),
        .fast      (fast),
        .horiz_req (horiz_req),
        .restart   (restart),
        .tick      (tick),
        .drop_due  (drop_due),
        .horiz_due (horiz_due)
    );

    // shape is read live, rotation is chosen outside
    collision_probe u_collision_probe (
        .shape (shape),
        .board (board),
        .probe (probe.check)
    );

    piece_motion_fsm u_motion (
        .Clk       (Clk),
        .reset     (reset),
        .keycode   (falling_piece_pkg::key_cmd_e'(keycode)),
        .keypress  (keypress),
        .tick      (tick),
        .drop_due  (drop_due),
        .horiz_due (horiz_due),
        .fast      (fast),
        .horiz_req (horiz_req),
        .restart   (restart),
        .probe     (probe.mover),
        .at_bottom (at_bottom),
        .x_pos     (x_pos),
        .y_pos     (y_pos)
    );

endmodule

`default_nettype wire

//--- bench/falling_piece_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "falling_piece_macros.svh"

module falling_piece_tb;

    localparam int clk_period  = 100;
    localparam int max_strobes = 384;   // landing loops counted at their limit
    localparam int timeout_ns  = (max_strobes * 8 + 6 * 12 + 100) * clk_period;
    localparam logic [15:0] o_mask       = 16'h0033;   // bit 4*r+c
    localparam logic [15:0] i_horiz_mask = 16'h000f;

    logic                            Clk;
    logic                            reset;
    logic                            frame_clk;
    logic [7:0]                      keycode;
    logic                            keypress;
    falling_piece_pkg::piece_shape_e shape;
    falling_piece_pkg::board_t       board;
    logic                            at_bottom;
    logic [`PIXEL_W-1:0]             x_pos;
    logic [`PIXEL_W-1:0]             y_pos;

    logic [31:0] lfsr = 32'h2a1f653e;
    logic [15:0] cur_mask;
    int exp_row;
    int exp_col;
    int drop_cnt;
    int horiz_cnt;
    int exp_landings;
    int pulse_cycles;
    int checks;
    int errors;
    int checks_at_start;
    int errors_at_start;

    falling_piece_top u_dut (
        .Clk       (Clk),
        .reset     (reset),
        .frame_clk (frame_clk),
        .keycode   (keycode),
        .keypress  (keypress),
        .shape     (shape),
        .board     (board),
        .at_bottom (at_bottom),
        .x_pos     (x_pos),
        .y_pos     (y_pos)
    );

    initial begin
        Clk = 1'b0;
        forever #(clk_period / 2) Clk = ~Clk;
    end

    always @(posedge Clk) begin
        if (reset)
            pulse_cycles <= 0;
        else if (at_bottom)
            pulse_cycles <= pulse_cycles + 1;   // one per landing if pulses are single
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hb4bcd35c) : (s >> 1);
    endfunction

    // a set cell outside the well or on an occupied cell
    function automatic bit collides(input logic [15:0] mask, input int row, input int col);
        int rr;
        int cc;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                rr = row + r;
                cc = col + c;
                if (mask[r * 4 + c] && (rr >= `GRID_ROWS || cc < 0 || cc >= `GRID_COLS))
                    return 1'b1;
                if (mask[r * 4 + c] && board[rr][cc])
                    return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic expect_equal(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            $display("CHECK FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // one tick of reference: landing first, then side step, then drop
    task automatic advance_model();
        bit fast;
        bit go_left;
        bit go_right;
        bit drop_due;
        bit horiz_due;
        fast     = keypress && keycode == falling_piece_pkg::KEY_DOWN;
        go_left  = keypress && keycode == falling_piece_pkg::KEY_LEFT;
        go_right = keypress && keycode == falling_piece_pkg::KEY_RIGHT;
        drop_cnt++;
        drop_due = drop_cnt >= (fast ? `FAST_DROP_TICKS : `DROP_TICKS);
        if (drop_due)
            drop_cnt = 0;
        horiz_due = 1'b0;
        if (go_left || go_right) begin
            horiz_cnt++;
            horiz_due = (horiz_cnt == `HORIZ_TICKS);
            if (horiz_due)
                horiz_cnt = 0;
        end
        if (collides(cur_mask, exp_row + 1, exp_col)) begin
            exp_landings++;
            exp_row   = `SPAWN_ROW;
            exp_col   = `SPAWN_COL;
            drop_cnt  = 0;
            horiz_cnt = 0;
        end else begin
            if (horiz_due && go_left && !collides(cur_mask, exp_row, exp_col - 1))
                exp_col--;
            else if (horiz_due && go_right && !collides(cur_mask, exp_row, exp_col + 1))
                exp_col++;
            if (drop_due)
                exp_row++;
        end
    endtask

    // 4 cycles high, 4 low, sampled 6 cycles after the rise
    task automatic frame_strobe();
        frame_clk = 1'b1;
        repeat (4) @(posedge Clk);
        #1 frame_clk = 1'b0;
        repeat (2) @(posedge Clk);
        #1;
        advance_model();
        expect_equal(x_pos, `ORIGIN_X + exp_col * `CELL_PIXELS, "x_pos");
        expect_equal(y_pos, `ORIGIN_Y + exp_row * `CELL_PIXELS, "y_pos");
        expect_equal(pulse_cycles, exp_landings, "at_bottom pulse cycles");
        repeat (2) @(posedge Clk);
        #1;
    endtask

    task automatic run_strobes(input int n);
        repeat (n) frame_strobe();
    endtask

    task automatic set_shape(input falling_piece_pkg::piece_shape_e s);
        shape    = s;
        cur_mask = (s == falling_piece_pkg::I_HORIZ) ? i_horiz_mask : o_mask;
    endtask

    task automatic hold_key(input falling_piece_pkg::key_cmd_e k);
        keycode  = k;
        keypress = 1'b1;
    endtask

    task automatic fill_random_rows(input int first_row);
        for (int r = first_row; r < `GRID_ROWS; r++) begin
            for (int c = 0; c < `GRID_COLS; c++) begin
                lfsr = lfsr_next(lfsr);
                board[r][c] = lfsr[0];
            end
        end
    endtask

    task automatic start_test();
        checks_at_start = checks;
        errors_at_start = errors;
        reset     = 1'b1;
        frame_clk = 1'b0;
        keypress  = 1'b0;
        keycode   = 8'h00;
        board     = '0;
        set_shape(falling_piece_pkg::O);
        repeat (10) @(posedge Clk);
        #1 reset = 1'b0;
        exp_row      = `SPAWN_ROW;
        exp_col      = `SPAWN_COL;
        drop_cnt     = 0;
        horiz_cnt    = 0;
        exp_landings = 0;
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - checks_at_start,
                 errors - errors_at_start);
    endtask

    task automatic wait_for_landing(input int exp_land_row);
        int start;
        int n;
        int rest_y;
        start = exp_landings;
        n = 0;
        rest_y = y_pos;
        while (exp_landings == start && n < 120) begin
            rest_y = y_pos;   // DUT row just before the landing tick
            frame_strobe();
            n++;
        end
        expect_equal(exp_landings - start, 1, "landings");
        expect_equal(rest_y, `ORIGIN_Y + exp_land_row * `CELL_PIXELS, "y_pos at rest");
        expect_equal(x_pos, 297, "x_pos after landing");
        expect_equal(y_pos, 135, "y_pos after landing");
    endtask

    task automatic reset_values();
        start_test();
        expect_equal(x_pos, 297, "x_pos after reset");
        expect_equal(y_pos, 135, "y_pos after reset");
        expect_equal(at_bottom, 0, "at_bottom after reset");
        finish_test("reset values");
    endtask

    task automatic normal_drop();
        int prev;
        int changes;
        start_test();
        prev = y_pos;
        changes = 0;
        repeat (50) begin
            frame_strobe();
            if (y_pos != prev)
                changes++;
            prev = y_pos;
        end
        expect_equal(changes, 1, "y_pos changes");
        expect_equal(y_pos, 135 + 9, "y_pos after 50 ticks");
        expect_equal(x_pos, 297, "x_pos after drop");
        finish_test("normal drop");
    endtask

    task automatic fast_drop();
        start_test();
        hold_key(falling_piece_pkg::KEY_DOWN);
        run_strobes(10);
        expect_equal(y_pos, 135 + 18, "y_pos after fast drop");
        finish_test("fast drop");
    endtask

    task automatic sideways_moves();
        start_test();
        hold_key(falling_piece_pkg::KEY_LEFT);
        run_strobes(24);
        expect_equal(x_pos, 270, "x_pos at left wall");
        set_shape(falling_piece_pkg::I_HORIZ);
        hold_key(falling_piece_pkg::KEY_RIGHT);
        run_strobes(48);
        expect_equal(x_pos, 270 + 7 * 9, "x_pos at right wall");
        finish_test("sideways moves");
    endtask

    task automatic landing();
        start_test();
        board[12] = '1;           // O comes to rest with anchor on row 10
        fill_random_rows(13);     // hidden below the full row
        hold_key(falling_piece_pkg::KEY_DOWN);
        wait_for_landing(10);
        board = '0;
        wait_for_landing(`GRID_ROWS - 2);
        finish_test("landing");
    endtask

    task automatic side_block();
        start_test();
        board[0][2] = 1'b1;       // next to the left column of the O
        fill_random_rows(5);
        hold_key(falling_piece_pkg::KEY_LEFT);
        run_strobes(12);
        expect_equal(x_pos, 297, "x_pos with left side blocked");
        finish_test("side block");
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog: tests did not finish within %0d ns", timeout_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        checks = 0;
        errors = 0;
        reset_values();
        normal_drop();
        fast_drop();
        sideways_moves();
        landing();
        side_block();
        $display("summary: %0d checks, %0d failed", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- falling_piece.f
+incdir+include
verilog/falling_piece_pkg.sv
verilog/probe_if.sv
verilog/shape_mask_rom.sv
verilog/collision_probe.sv
verilog/step_timer.sv
verilog/piece_motion_fsm.sv
verilog/falling_piece_top.sv
bench/falling_piece_tb.sv

//--- Makefile
# override any of these on the command line, e.g. make sim LOG=run.log
VERILATOR ?= verilator
TOP       ?= falling_piece_tb
FILELIST  ?= falling_piece.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "simulation gave no result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
